// File: cw_bus_pkg.sv
package cw_bus_pkg;

   // Register bus widths
   localparam int ADDR_W = 6;
   localparam int DATA_W = 8;

   // Address map
   localparam logic [ADDR_W-1:0] ADDR_TRIG_SEL      = 6'd1;
   localparam logic [ADDR_W-1:0] ADDR_IO_CTRL       = 6'd2;
   localparam logic [ADDR_W-1:0] ADDR_GLITCH_OFFSET = 6'd3;
   localparam logic [ADDR_W-1:0] ADDR_GLITCH_WIDTH  = 6'd4;
   localparam logic [ADDR_W-1:0] ADDR_GLITCH_COUNT  = 6'd5; // Read only

   // One register bus cycle as seen by the register blocks.
   // Write is a single cycle strobe, read stays high for the whole
   // USB read so the blocks can present data combinationally
   typedef struct packed {
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic              write;   // 1-cycle strobe
      logic              read;    // Level during read
   } reg_bus_t;

endpackage

// File: cw_target_pkg.sv
package cw_target_pkg;

   // Number of target I/O lines usable as trigger sources
   localparam int TARGET_IO_W = 4;

   // Trigger select register, use_io1 sits in bit 0
   typedef struct packed {
      logic [2:0] spare;
      logic       mode_and;   // 0 = OR, 1 = AND of selected lines
      logic       use_io4;
      logic       use_io3;
      logic       use_io2;
      logic       use_io1;
   } trig_sel_t;

   // Target pin control register, enable_avrprog sits in bit 0
   typedef struct packed {
      logic [3:0] spare;
      logic       nrst_value;        // Level driven on nRST when enabled
      logic       enable_nrst;
      logic       target_power_off;
      logic       enable_avrprog;    // USB SPI owns the programming pins
   } io_ctrl_t;

   // Glitch configuration, both fields in clock cycles
   typedef struct packed {
      logic [7:0] offset;
      logic [7:0] width;
   } glitch_cfg_t;

endpackage

// File: usb_reg_fsm.sv
`timescale 1ns/100ps

module usb_reg_fsm (
   input  logic                          clk_usb_buf,
   input  logic                          rst_n_i,
   input  logic [7:0]                    usb_addr_i,
   input  logic [cw_bus_pkg::DATA_W-1:0] usb_data_i,
   input  logic                          usb_ale_n_i,
   input  logic                          usb_rd_n_i,
   input  logic                          usb_wr_n_i,
   input  logic                          usb_ce_n_i,
   input  logic [cw_bus_pkg::DATA_W-1:0] rdata_i,
   output logic [cw_bus_pkg::DATA_W-1:0] usb_data_o,
   output logic                          usb_data_oe_o,
   output cw_bus_pkg::reg_bus_t          reg_bus_o
);
   import cw_bus_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      WRITE_HOLD,
      READ
   } state_t;

   state_t            state_q;
   state_t            state_d;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [DATA_W-1:0] rdata_q;
   logic              wr_req;
   logic              rd_req;

   assign wr_req = ~usb_wr_n_i & ~usb_ce_n_i;
   assign rd_req = ~usb_rd_n_i & ~usb_ce_n_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (wr_req)
               state_d = WRITE;      // Write wins if both strobes are low
            else if (rd_req)
               state_d = READ;
         end
         WRITE:      state_d = usb_wr_n_i ? IDLE : WRITE_HOLD;
         WRITE_HOLD: state_d = usb_wr_n_i ? IDLE : WRITE_HOLD; // Wait out the low period
         READ:       state_d = rd_req ? READ : IDLE;
         default:    state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // Address, write data and read data latches
   always_ff @(posedge clk_usb_buf) begin
      if (!usb_ale_n_i)
         addr_q <= usb_addr_i[ADDR_W-1:0]; // Upper address bits unused
      if (state_q == IDLE && wr_req)
         wdata_q <= usb_data_i;
      if (state_q == READ)
         rdata_q <= rdata_i;
   end

   always_comb begin
      reg_bus_o.addr  = addr_q;
      reg_bus_o.wdata = wdata_q;
      reg_bus_o.write = (state_q == WRITE);
      reg_bus_o.read  = (state_q == READ);
   end

   assign usb_data_o    = rdata_q;
   assign usb_data_oe_o = (state_q == READ);

endmodule

// File: reg_target_io.sv
`timescale 1ns/100ps

module reg_target_io (
   input  logic                                  clk_usb_buf,
   input  logic                                  rst_n_i,
   input  cw_bus_pkg::reg_bus_t                  reg_bus_i,
   input  logic [cw_target_pkg::TARGET_IO_W-1:0] target_io_i,
   output logic [cw_bus_pkg::DATA_W-1:0]         rdata_o,
   output logic                                  trigger_o,
   output cw_target_pkg::io_ctrl_t               io_ctrl_o
);
   import cw_bus_pkg::*;
   import cw_target_pkg::*;

   trig_sel_t              trig_sel_q;
   io_ctrl_t               io_ctrl_q;
   logic [TARGET_IO_W-1:0] sel;
   logic [TARGET_IO_W-1:0] hit;
   logic                   trig_comb;
   logic                   trig_q;

   assign sel = {trig_sel_q.use_io4, trig_sel_q.use_io3,
                 trig_sel_q.use_io2, trig_sel_q.use_io1};
   assign hit = sel & target_io_i;

   // Nothing selected never triggers, even in AND mode
   always_comb begin
      if (sel == '0)
         trig_comb = 1'b0;
      else if (trig_sel_q.mode_and)
         trig_comb = (hit == sel);
      else
         trig_comb = |hit;
   end

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         trig_sel_q <= '0;
         io_ctrl_q  <= '0;
         trig_q     <= 1'b0;
      end else begin
         trig_q <= trig_comb;
         if (reg_bus_i.write) begin
            case (reg_bus_i.addr)
               ADDR_TRIG_SEL: trig_sel_q <= trig_sel_t'(reg_bus_i.wdata);
               ADDR_IO_CTRL:  io_ctrl_q  <= io_ctrl_t'(reg_bus_i.wdata);
               default:       ;
            endcase
         end
      end
   end

   // Read mux, zero unless one of our addresses is being read
   always_comb begin
      rdata_o = '0;
      if (reg_bus_i.read) begin
         case (reg_bus_i.addr)
            ADDR_TRIG_SEL: rdata_o = trig_sel_q;
            ADDR_IO_CTRL:  rdata_o = io_ctrl_q;
            default:       rdata_o = '0;
         endcase
      end
   end

   assign trigger_o = trig_q;
   assign io_ctrl_o = io_ctrl_q;

endmodule

// File: glitch_timer.sv
`timescale 1ns/100ps

module glitch_timer (
   input  logic                          clk_usb_buf,
   input  logic                          rst_n_i,
   input  cw_bus_pkg::reg_bus_t          reg_bus_i,
   input  logic                          trigger_i,
   output logic [cw_bus_pkg::DATA_W-1:0] rdata_o,
   output logic                          glitch_o
);
   import cw_bus_pkg::*;
   import cw_target_pkg::*;

   typedef enum logic [1:0] {
      PH_IDLE,
      PH_OFFSET,
      PH_WIDTH
   } phase_t;

   glitch_cfg_t       cfg_q;
   phase_t            phase_q;
   logic [DATA_W-1:0] cnt_q;     // Shared down-counter for both phases
   logic [DATA_W-1:0] count_q;   // Completed pulses
   logic              trig_d;
   logic              trig_rise;

   assign trig_rise = trigger_i & ~trig_d;

   always_ff @(posedge clk_usb_buf or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cfg_q   <= '0;
         phase_q <= PH_IDLE;
         cnt_q   <= '0;
         count_q <= '0;
         trig_d  <= 1'b0;
      end else begin
         trig_d <= trigger_i;
         if (reg_bus_i.write) begin
            case (reg_bus_i.addr)
               ADDR_GLITCH_OFFSET: cfg_q.offset <= reg_bus_i.wdata;
               ADDR_GLITCH_WIDTH:  cfg_q.width  <= reg_bus_i.wdata;
               default:            ;
            endcase
         end
         case (phase_q)
            PH_IDLE: begin
               // Edges are only taken here, so retriggers are ignored
               if (trig_rise && cfg_q.width != '0) begin
                  if (cfg_q.offset <= 8'd1) begin
                     phase_q <= PH_WIDTH;  // Pulse starts in the next cycle
                     cnt_q   <= cfg_q.width - 8'd1;
                  end else begin
                     phase_q <= PH_OFFSET;
                     cnt_q   <= cfg_q.offset - 8'd2;
                  end
               end
            end
            PH_OFFSET: begin
               if (cnt_q != '0)
                  cnt_q <= cnt_q - 8'd1;
               else if (cfg_q.width == '0)
                  phase_q <= PH_IDLE;      // Width cleared while pending
               else begin
                  phase_q <= PH_WIDTH;
                  cnt_q   <= cfg_q.width - 8'd1;
               end
            end
            PH_WIDTH: begin
               if (cnt_q != '0)
                  cnt_q <= cnt_q - 8'd1;
               else begin
                  phase_q <= PH_IDLE;
                  count_q <= count_q + 8'd1; // Wraps at 8 bits
               end
            end
            default: phase_q <= PH_IDLE;
         endcase
      end
   end

   always_comb begin
      rdata_o = '0;
      if (reg_bus_i.read) begin
         case (reg_bus_i.addr)
            ADDR_GLITCH_OFFSET: rdata_o = cfg_q.offset;
            ADDR_GLITCH_WIDTH:  rdata_o = cfg_q.width;
            ADDR_GLITCH_COUNT:  rdata_o = count_q;
            default:            rdata_o = '0;
         endcase
      end
   end

   assign glitch_o = (phase_q == PH_WIDTH);

endmodule

// File: target_pin_mux.sv
`timescale 1ns/100ps

module target_pin_mux (
   input  cw_target_pkg::io_ctrl_t io_ctrl_i,
   input  logic                    usb_treset_i,
   input  logic                    usb_spi_mosi_i,
   input  logic                    usb_spi_sck_i,
   input  logic                    target_miso_i,
   input  logic                    ext_miso_i,
   output logic                    target_nrst_o,
   output logic                    target_nrst_oe_o,
   output logic                    target_mosi_o,
   output logic                    target_sck_o,
   output logic                    target_spi_oe_o,
   output logic                    usb_spi_miso_o,
   output logic                    target_power_off_o
);
   import cw_target_pkg::*;

   logic powered;
   logic nrst_val;

   assign powered = ~io_ctrl_i.target_power_off;

   // Programmer reset has priority over the register-driven level
   assign nrst_val = io_ctrl_i.enable_avrprog ? usb_treset_i : io_ctrl_i.nrst_value;

   assign target_nrst_oe_o = powered & (io_ctrl_i.enable_avrprog | io_ctrl_i.enable_nrst);
   assign target_spi_oe_o  = powered & io_ctrl_i.enable_avrprog;

   // Values read as 0 whenever the pin is not driven
   assign target_nrst_o = target_nrst_oe_o & nrst_val;
   assign target_mosi_o = target_spi_oe_o & usb_spi_mosi_i;
   assign target_sck_o  = target_spi_oe_o & usb_spi_sck_i;

   assign usb_spi_miso_o     = io_ctrl_i.enable_avrprog ? target_miso_i : ext_miso_i;
   assign target_power_off_o = io_ctrl_i.target_power_off;

endmodule

// File: cw_lite_core.sv
`timescale 1ns/100ps

module cw_lite_core (
   input  logic                                  clk_usb_buf,
   input  logic                                  rst_n_i,
   input  logic [7:0]                            usb_addr_i,
   input  logic [cw_bus_pkg::DATA_W-1:0]         usb_data_i,
   input  logic                                  usb_ale_n_i,
   input  logic                                  usb_rd_n_i,
   input  logic                                  usb_wr_n_i,
   input  logic                                  usb_ce_n_i,
   output logic [cw_bus_pkg::DATA_W-1:0]         usb_data_o,
   output logic                                  usb_data_oe_o,
   input  logic [cw_target_pkg::TARGET_IO_W-1:0] target_io_i,
   input  logic                                  usb_treset_i,
   input  logic                                  usb_spi_mosi_i,
   input  logic                                  usb_spi_sck_i,
   input  logic                                  target_miso_i,
   input  logic                                  ext_miso_i,
   output logic                                  target_nrst_o,
   output logic                                  target_nrst_oe_o,
   output logic                                  target_mosi_o,
   output logic                                  target_sck_o,
   output logic                                  target_spi_oe_o,
   output logic                                  usb_spi_miso_o,
   output logic                                  target_power_off_o,
   output logic                                  trigger_out_o,
   output logic                                  glitch_out_o
);

   cw_bus_pkg::reg_bus_t                  reg_bus;
   cw_target_pkg::io_ctrl_t               io_ctrl;
   logic [cw_bus_pkg::DATA_W-1:0]         rdata_tio;
   logic [cw_bus_pkg::DATA_W-1:0]         rdata_glitch;
   logic                                  trigger;

   usb_reg_fsm usb_reg_fsm_i (
      .clk_usb_buf   (clk_usb_buf),
      .rst_n_i       (rst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_ale_n_i   (usb_ale_n_i),
      .usb_rd_n_i    (usb_rd_n_i),
      .usb_wr_n_i    (usb_wr_n_i),
      .usb_ce_n_i    (usb_ce_n_i),
      .rdata_i       (rdata_tio | rdata_glitch), // Unselected blocks return 0
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_bus_o     (reg_bus)
   );

   reg_target_io reg_target_io_i (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .reg_bus_i   (reg_bus),
      .target_io_i (target_io_i),
      .rdata_o     (rdata_tio),
      .trigger_o   (trigger),
      .io_ctrl_o   (io_ctrl)
   );

   glitch_timer glitch_timer_i (
      .clk_usb_buf (clk_usb_buf),
      .rst_n_i     (rst_n_i),
      .reg_bus_i   (reg_bus),
      .trigger_i   (trigger),
      .rdata_o     (rdata_glitch),
      .glitch_o    (glitch_out_o)
   );

   target_pin_mux target_pin_mux_i (
      .io_ctrl_i          (io_ctrl),
      .usb_treset_i       (usb_treset_i),
      .usb_spi_mosi_i     (usb_spi_mosi_i),
      .usb_spi_sck_i      (usb_spi_sck_i),
      .target_miso_i      (target_miso_i),
      .ext_miso_i         (ext_miso_i),
      .target_nrst_o      (target_nrst_o),
      .target_nrst_oe_o   (target_nrst_oe_o),
      .target_mosi_o      (target_mosi_o),
      .target_sck_o       (target_sck_o),
      .target_spi_oe_o    (target_spi_oe_o),
      .usb_spi_miso_o     (usb_spi_miso_o),
      .target_power_off_o (target_power_off_o)
   );

   assign trigger_out_o = trigger;

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
   parameter int PERIOD_NS  = 10,
   parameter int RST_CYCLES = 8
) (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2) clk_o = ~clk_o;
   end

   initial begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_n_o = 1'b1;   // Released away from the active edge
   end

endmodule

// File: tb_cw_lite.sv
`timescale 1ns/100ps

module tb_cw_lite;
   import cw_bus_pkg::*;
   import cw_target_pkg::*;

   // Test lengths in cycles, also used to size the watchdog
   localparam int N_RW = 40;
   localparam int N_TRIG = 8;
   localparam int TRIG_LEN = 24;
   localparam int N_GL = 12;
   localparam int GL_LEN = 50;
   localparam int N_WRAP = 300;
   localparam int N_PIN = 16;
   localparam int PIN_LEN = 6;
   localparam int WR_LEN = 4;
   localparam int RD_MAX = 12;
   localparam int WATCHDOG_CYC = 10 + 5 * RD_MAX + (N_RW + 2) * (WR_LEN + RD_MAX)
      + N_TRIG * (1 + WR_LEN + TRIG_LEN) + 2 * 255 + N_GL * (50 + 3 * WR_LEN + GL_LEN)
      + 50 + 2 * N_WRAP + 3 * WR_LEN + RD_MAX + N_PIN * (WR_LEN + PIN_LEN) + 200;

   logic       clk_usb_buf;
   logic       rst_n;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic       usb_ale_n_i;
   logic       usb_rd_n_i;
   logic       usb_wr_n_i;
   logic       usb_ce_n_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic [3:0] target_io_i;
   logic       usb_treset_i;
   logic       usb_spi_mosi_i;
   logic       usb_spi_sck_i;
   logic       target_miso_i;
   logic       ext_miso_i;
   logic       target_nrst_o;
   logic       target_nrst_oe_o;
   logic       target_mosi_o;
   logic       target_sck_o;
   logic       target_spi_oe_o;
   logic       usb_spi_miso_o;
   logic       target_power_off_o;
   logic       trigger_out_o;
   logic       glitch_out_o;

   // Model state
   logic [7:0]  regs [0:63];   // Register image, index is the address
   logic [7:0]  count_m;
   logic        trig_m;
   logic        trig_prev;
   int          n;             // Cycle number, one per tick
   int          start_at;
   int          end_at;        // Last cycle of the current pulse
   int          errors;
   int          checks;
   int          err_base;
   logic [31:0] rng_state = 32'd21514;

   tb_clock_gen clk_gen_i (
      .clk_o   (clk_usb_buf),
      .rst_n_o (rst_n)
   );

   cw_lite_core dut_i (
      .clk_usb_buf        (clk_usb_buf),
      .rst_n_i            (rst_n),
      .usb_addr_i         (usb_addr_i),
      .usb_data_i         (usb_data_i),
      .usb_ale_n_i        (usb_ale_n_i),
      .usb_rd_n_i         (usb_rd_n_i),
      .usb_wr_n_i         (usb_wr_n_i),
      .usb_ce_n_i         (usb_ce_n_i),
      .usb_data_o         (usb_data_o),
      .usb_data_oe_o      (usb_data_oe_o),
      .target_io_i        (target_io_i),
      .usb_treset_i       (usb_treset_i),
      .usb_spi_mosi_i     (usb_spi_mosi_i),
      .usb_spi_sck_i      (usb_spi_sck_i),
      .target_miso_i      (target_miso_i),
      .ext_miso_i         (ext_miso_i),
      .target_nrst_o      (target_nrst_o),
      .target_nrst_oe_o   (target_nrst_oe_o),
      .target_mosi_o      (target_mosi_o),
      .target_sck_o       (target_sck_o),
      .target_spi_oe_o    (target_spi_oe_o),
      .usb_spi_miso_o     (usb_spi_miso_o),
      .target_power_off_o (target_power_off_o),
      .trigger_out_o      (trigger_out_o),
      .glitch_out_o       (glitch_out_o)
   );

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // OR or AND of the selected lines, nothing selected gives 0
   function automatic logic trig_model(input logic [7:0] sel_raw, input logic [3:0] io);
      trig_sel_t  sel;
      logic [3:0] use_m;
      sel = trig_sel_t'(sel_raw);
      use_m = {sel.use_io4, sel.use_io3, sel.use_io2, sel.use_io1};
      if (use_m == 4'd0)
         return 1'b0;
      if (sel.mode_and)
         return (io & use_m) == use_m;
      return |(io & use_m);
   endfunction

   function automatic logic [7:0] expect_read(input logic [5:0] a);
      if (a >= ADDR_TRIG_SEL && a <= ADDR_GLITCH_WIDTH)
         return regs[a];
      if (a == ADDR_GLITCH_COUNT)
         return count_m;
      return 8'd0;   // Unmapped
   endfunction

   task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // One clock cycle; trigger and glitch are compared in every cycle
   task automatic tick();
      logic exp_glitch;
      @(negedge clk_usb_buf);
      n++;
      trig_prev = trig_m;
      trig_m = trig_model(regs[ADDR_TRIG_SEL], target_io_i);
      if (trig_m && !trig_prev && n > end_at && regs[ADDR_GLITCH_WIDTH] != 8'd0) begin
         start_at = n + ((regs[ADDR_GLITCH_OFFSET] > 8'd1) ? int'(regs[ADDR_GLITCH_OFFSET]) : 1);
         end_at = start_at + int'(regs[ADDR_GLITCH_WIDTH]) - 1;
         count_m = count_m + 8'd1;   // Byte wraps like the hardware
      end
      exp_glitch = (n >= start_at && n <= end_at);
      check("trigger_out_o", 8'(trigger_out_o), 8'(trig_m));
      check("glitch_out_o", 8'(glitch_out_o), 8'(exp_glitch));
   endtask

   task automatic write_reg(input logic [5:0] a, input logic [7:0] d);
      usb_addr_i = {2'b11, a};   // Upper bits must be ignored
      usb_ale_n_i = 1'b0;
      tick();
      usb_ale_n_i = 1'b1;
      usb_data_i = d;
      usb_wr_n_i = 1'b0;
      usb_ce_n_i = 1'b0;
      tick();
      tick();                    // Long strobe, still one write
      usb_wr_n_i = 1'b1;
      usb_ce_n_i = 1'b1;
      tick();
      if (a >= ADDR_TRIG_SEL && a <= ADDR_GLITCH_WIDTH)
         regs[a] = d;
   endtask

   task automatic read_expect(input logic [5:0] a, input logic [7:0] exp);
      int w;
      usb_addr_i = {2'b10, a};
      usb_ale_n_i = 1'b0;
      tick();
      usb_ale_n_i = 1'b1;
      usb_rd_n_i = 1'b0;
      usb_ce_n_i = 1'b0;
      w = 0;
      do begin
         tick();
         w++;
      end while (!usb_data_oe_o && w < RD_MAX);
      if (!usb_data_oe_o) begin
         errors++;
         $display("Read of address %0d never raised usb_data_oe_o at %0t", a, $time);
      end
      tick();
      check("usb_data_oe_o", 8'(usb_data_oe_o), 8'd1);
      check("usb_data_o", usb_data_o, exp);
      usb_rd_n_i = 1'b1;
      usb_ce_n_i = 1'b1;
      tick();
      check("usb_data_oe_o", 8'(usb_data_oe_o), 8'd0);
   endtask

   // Quiet trigger lines and let any pulse finish
   task automatic settle();
      target_io_i = 4'd0;
      tick();
      while (n <= end_at)
         tick();
      tick();
   endtask

   task automatic check_pins();
      io_ctrl_t c;
      logic     nrst_oe;
      logic     spi_oe;
      c = io_ctrl_t'(regs[ADDR_IO_CTRL]);
      nrst_oe = !c.target_power_off && (c.enable_avrprog || c.enable_nrst);
      spi_oe = !c.target_power_off && c.enable_avrprog;
      check("target_nrst_oe_o", 8'(target_nrst_oe_o), 8'(nrst_oe));
      check("target_nrst_o", 8'(target_nrst_o),
            8'(nrst_oe & (c.enable_avrprog ? usb_treset_i : c.nrst_value)));
      check("target_spi_oe_o", 8'(target_spi_oe_o), 8'(spi_oe));
      check("target_mosi_o", 8'(target_mosi_o), 8'(spi_oe & usb_spi_mosi_i));
      check("target_sck_o", 8'(target_sck_o), 8'(spi_oe & usb_spi_sck_i));
      check("usb_spi_miso_o", 8'(usb_spi_miso_o),
            8'(c.enable_avrprog ? target_miso_i : ext_miso_i));
      check("target_power_off_o", 8'(target_power_off_o), 8'(c.target_power_off));
   endtask

   task automatic report_test(input string name);
      $display("test %-14s done, %0d errors", name, errors - err_base);
      err_base = errors;
   endtask

   initial begin
      #(WATCHDOG_CYC * 10);
      $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG_CYC);
      $display("ERRORS FOUND");
      $finish;
   end

   initial begin
      logic [31:0] r;
      logic [5:0]  a;
      usb_addr_i = 8'd0;
      usb_data_i = 8'd0;
      usb_ale_n_i = 1'b1;
      usb_rd_n_i = 1'b1;
      usb_wr_n_i = 1'b1;
      usb_ce_n_i = 1'b1;
      target_io_i = 4'd0;
      usb_treset_i = 1'b0;
      usb_spi_mosi_i = 1'b0;
      usb_spi_sck_i = 1'b0;
      target_miso_i = 1'b0;
      ext_miso_i = 1'b0;
      for (int i = 0; i < 64; i++)
         regs[i] = 8'd0;
      count_m = 8'd0;
      trig_m = 1'b0;
      n = 0;
      start_at = 0;
      end_at = -1;
      errors = 0;
      checks = 0;
      err_base = 0;
      @(posedge rst_n);

      tick();
      check("usb_data_oe_o", 8'(usb_data_oe_o), 8'd0);
      check_pins();
      for (int i = 1; i <= 5; i++)
         read_expect(6'(i), 8'd0);
      report_test("reset");

      for (int i = 0; i < N_RW; i++) begin
         r = next_rand();
         a = r[9] ? r[5:0] : {3'b000, r[2:0]};   // Mostly near the map
         write_reg(a, r[23:16]);
         read_expect(a, expect_read(a));
      end
      // Read-only and unmapped addresses must not take a write
      write_reg(ADDR_GLITCH_COUNT, 8'h5a);
      read_expect(ADDR_GLITCH_COUNT, expect_read(ADDR_GLITCH_COUNT));
      write_reg(6'd63, 8'ha5);
      read_expect(6'd63, expect_read(6'd63));
      report_test("register_rw");

      for (int i = 0; i < N_TRIG; i++) begin
         target_io_i = 4'd0;
         tick();
         r = next_rand();
         write_reg(ADDR_TRIG_SEL, r[7:0]);
         for (int k = 0; k < TRIG_LEN; k++) begin
            r = next_rand();
            target_io_i = r[3:0];
            tick();
         end
      end
      report_test("trigger");

      for (int i = 0; i < N_GL; i++) begin
         settle();
         r = next_rand();
         write_reg(ADDR_GLITCH_OFFSET, {3'b000, r[12:8]});
         write_reg(ADDR_GLITCH_WIDTH, (r[1:0] == 2'b00) ? 8'd0 : {4'b0000, r[7:4]});
         write_reg(ADDR_TRIG_SEL, r[23:16]);
         for (int k = 0; k < GL_LEN; k++) begin
            r = next_rand();
            target_io_i = r[3:0];
            tick();
         end
      end
      report_test("glitch_timing");

      // Back-to-back one-cycle pulses, enough to wrap the count
      settle();
      write_reg(ADDR_GLITCH_OFFSET, 8'd0);
      write_reg(ADDR_GLITCH_WIDTH, 8'd1);
      write_reg(ADDR_TRIG_SEL, 8'h01);
      for (int k = 0; k < N_WRAP; k++) begin
         target_io_i = 4'h1;
         tick();
         target_io_i = 4'h0;
         tick();
      end
      settle();
      read_expect(ADDR_GLITCH_COUNT, count_m);
      report_test("glitch_count");

      for (int i = 0; i < N_PIN; i++) begin
         r = next_rand();
         write_reg(ADDR_IO_CTRL, r[7:0]);
         for (int k = 0; k < PIN_LEN; k++) begin
            r = next_rand();
            usb_treset_i = r[0];
            usb_spi_mosi_i = r[1];
            usb_spi_sck_i = r[2];
            target_miso_i = r[3];
            ext_miso_i = r[4];
            tick();
            check_pins();
         end
      end
      report_test("pin_steering");

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: compile.f
cw_bus_pkg.sv
cw_target_pkg.sv
usb_reg_fsm.sv
reg_target_io.sv
glitch_timer.sv
target_pin_mux.sv
cw_lite_core.sv
tb_clock_gen.sv
tb_cw_lite.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module tb_cw_lite \
   -f compile.f -o sim_cw_lite \
   && ./obj_dir/sim_cw_lite > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
